//--- bench/cam_dma_assertions.sv
/*
 * DMA window and FIFO head checks
 * Bound into the DMA writer, which also sees the FIFO head and empty flag
 */
module cam_dma_assertions (
   input logic                   mipi_pclk,
   input logic                   rst_n,
   input logic                   cam_dma_init_done,
   input logic                   fifo_empty,
   input cam_dma_pkg::rgb_pair_t fifo_rdata,
   input logic                   dma_write,
   input logic                   cam_dma_wvalid,
   input logic                   cam_dma_wlast
);
   timeunit 1ns;
   timeprecision 1ps;

   // Read by the testbench at the end of the run
   int fail_count = 0;

   // Three synchroniser flops, then the window is open
   window_opens : assert property (@(posedge mipi_pclk) disable iff (!rst_n)
      $rose(cam_dma_init_done) |-> ##3 dma_write)
      else begin
         fail_count++;
         $error("write window did not open after init_done rose");
      end

   // Last beat closes the window unless a new init edge arrives with it
   window_closes : assert property (@(posedge mipi_pclk) disable iff (!rst_n)
      cam_dma_wlast && !$past(cam_dma_init_done, 2) |=> !dma_write)
      else begin
         fail_count++;
         $error("write window still open after the last beat");
      end

   // Head word stays put while nothing is popped
   head_held : assert property (@(posedge mipi_pclk) disable iff (!rst_n)
      !fifo_empty && !cam_dma_wvalid |=> $stable(fifo_rdata))
      else begin
         fail_count++;
         $error("FIFO head word changed without a pop");
      end

endmodule

bind cam_dma_writer cam_dma_assertions writer_checks (
   .mipi_pclk         (mipi_pclk),
   .rst_n             (rst_n),
   .cam_dma_init_done (cam_dma_init_done),
   .fifo_empty        (fifo_empty),
   .fifo_rdata        (fifo_rdata),
   .dma_write         (dma_write),
   .cam_dma_wvalid    (cam_dma_wvalid),
   .cam_dma_wlast     (cam_dma_wlast)
);

//--- bench/cam_dma_tb.sv
/*
 * Camera DMA back end testbench
 * Directed capture, grayscale, back-pressure, overflow and frame rate tests
 */
`include "cam_dma_defines.svh"

module cam_dma_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int          TRANSFER_LEN = 16;
   localparam int          FRAME_PAIRS  = 16;
   localparam logic [31:0] LFSR_SEED    = 32'd99856;
   localparam logic [31:0] LFSR_TAPS    = 32'hB4BC_D35C;
   // Rough length of each test in clock cycles
   localparam int          TEST_CYCLES  = 40 + 200 + 200 + 300 + 300 + 1050;
   localparam int          BEAT_WAIT    = 600;

   logic                   mipi_pclk = 1'b0;
   logic                   rst_n;
   logic                   cam_vsync;
   logic                   pix_valid;
   cam_dma_pkg::rgb_pair_t pix_data;
   logic                   trigger_capture_frame;
   logic                   continuous_capture_frame;
   logic                   rgb_gray;
   logic                   cam_dma_init_done;
   logic                   cam_dma_wready;
   logic                   cam_dma_wvalid;
   logic                   cam_dma_wlast;
   cam_dma_pkg::dma_word_t cam_dma_wdata;
   logic                   debug_fifo_overflow;
   logic                   debug_fifo_underflow;
   logic [31:0]            debug_fifo_wcount;
   logic [31:0]            debug_fifo_rcount;
   logic [2:0]             debug_dma_status;
   logic [31:0]            frames_per_second;

   logic [31:0]            lfsr;
   logic                   ready_random;
   logic                   gray_on;
   int                     errors;
   int                     assert_fails;
   string                  test_name;
   cam_dma_pkg::dma_word_t exp_words [$];
   cam_dma_pkg::dma_word_t rx_words [$];
   logic                   rx_last [$];

   always #10 mipi_pclk = ~mipi_pclk;

   cam_dma_top #(
      .TRANSFER_LEN (TRANSFER_LEN),
      .CLK_RATE     (999)
   ) cam_dma_top_inst (
      .mipi_pclk                (mipi_pclk),
      .rst_n                    (rst_n),
      .cam_vsync                (cam_vsync),
      .pix_valid                (pix_valid),
      .pix_data                 (pix_data),
      .trigger_capture_frame    (trigger_capture_frame),
      .continuous_capture_frame (continuous_capture_frame),
      .rgb_gray                 (rgb_gray),
      .cam_dma_init_done        (cam_dma_init_done),
      .cam_dma_wready           (cam_dma_wready),
      .cam_dma_wvalid           (cam_dma_wvalid),
      .cam_dma_wlast            (cam_dma_wlast),
      .cam_dma_wdata            (cam_dma_wdata),
      .debug_fifo_overflow      (debug_fifo_overflow),
      .debug_fifo_underflow     (debug_fifo_underflow),
      .debug_fifo_wcount        (debug_fifo_wcount),
      .debug_fifo_rcount        (debug_fifo_rcount),
      .debug_dma_status         (debug_dma_status),
      .frames_per_second        (frames_per_second)
   );

   // Beats are sampled mid-cycle, before the edge that transfers them
   always @(negedge mipi_pclk) begin
      if (cam_dma_wvalid === 1'b1) begin
         rx_words.push_back(cam_dma_wdata);
         rx_last.push_back(cam_dma_wlast);
      end
   end

   //////////////////////////////////////////////////
   // Random source and pixel model
   //////////////////////////////////////////////////

   function automatic logic next_bit();
      logic out;
      out  = lfsr[0];
      lfsr = lfsr >> 1;
      if (out) begin
         lfsr = lfsr ^ LFSR_TAPS;
      end
      return out;
   endfunction

   function automatic logic [7:0] rand_byte();
      logic [7:0] b;
      b = '0;
      for (int i = 0; i < 8; i++) begin
         b = {b[6:0], next_bit()};
      end
      return b;
   endfunction

   function automatic cam_dma_pkg::rgb_pair_t random_pair();
      cam_dma_pkg::rgb_pair_t p;
      for (int i = 0; i < 2; i++) begin
         p[i].r = rand_byte();
         p[i].g = rand_byte();
         p[i].b = rand_byte();
      end
      return p;
   endfunction

   // Luma is the weighted sum over 256, truncated
   function automatic cam_dma_pkg::rgb_pix_t gray_pix(input cam_dma_pkg::rgb_pix_t p);
      int         sum;
      logic [7:0] y;
      sum = `CAM_GRAY_WR * p.r + `CAM_GRAY_WG * p.g + `CAM_GRAY_WB * p.b;
      y   = sum[15:8];
      return {y, y, y};
   endfunction

   // Zero byte then blue, green, red for each pixel, pixel 1 on top
   function automatic cam_dma_pkg::dma_word_t model_word(input cam_dma_pkg::rgb_pair_t p,
                                                         input logic gray);
      cam_dma_pkg::rgb_pix_t q0;
      cam_dma_pkg::rgb_pix_t q1;
      q0 = gray ? gray_pix(p[0]) : p[0];
      q1 = gray ? gray_pix(p[1]) : p[1];
      return {8'h00, q1.b, q1.g, q1.r, 8'h00, q0.b, q0.g, q0.r};
   endfunction

   //////////////////////////////////////////////////
   // Compare tasks
   //////////////////////////////////////////////////

   task automatic check_dma_word(input string what, input cam_dma_pkg::dma_word_t exp,
                                 input cam_dma_pkg::dma_word_t act);
      if (act !== exp) begin
         $display("FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
         errors++;
      end
   endtask

   task automatic check_bit(input string what, input logic exp, input logic act);
      if (act !== exp) begin
         $display("FAILED %s %s: expected %b, actual %b", test_name, what, exp, act);
         errors++;
      end
   endtask

   task automatic check_count(input string what, input logic [31:0] exp,
                              input logic [31:0] act);
      if (act !== exp) begin
         $display("FAILED %s %s: expected %0d, actual %0d", test_name, what, exp, act);
         errors++;
      end
   endtask

   //////////////////////////////////////////////////
   // Stimulus helpers
   //////////////////////////////////////////////////

   task automatic next_cycle();
      @(posedge mipi_pclk);
      #2;
      if (ready_random) begin
         cam_dma_wready = next_bit();
      end
   endtask

   task automatic apply_reset();
      rst_n                    = 1'b0;
      cam_vsync                = 1'b0;
      pix_valid                = 1'b0;
      trigger_capture_frame    = 1'b0;
      continuous_capture_frame = 1'b0;
      rgb_gray                 = 1'b0;
      cam_dma_init_done        = 1'b0;
      cam_dma_wready           = 1'b0;
      ready_random             = 1'b0;
      gray_on                  = 1'b0;
      repeat (16) next_cycle();
      rst_n = 1'b1;
      exp_words.delete();
      rx_words.delete();
      rx_last.delete();
   endtask

   // Vsync gap, then pixel pairs; only the first n_keep should reach the DMA
   task automatic send_frame(input int n_pairs, input int n_keep);
      cam_dma_pkg::rgb_pair_t p;
      cam_vsync = 1'b1;
      repeat (4) next_cycle();
      cam_vsync = 1'b0;
      repeat (2) next_cycle();
      for (int i = 0; i < n_pairs; i++) begin
         p         = random_pair();
         pix_data  = p;
         pix_valid = 1'b1;
         if (i < n_keep) begin
            exp_words.push_back(model_word(p, gray_on));
         end
         next_cycle();
      end
      pix_valid = 1'b0;
      repeat (4) next_cycle();
   endtask

   task automatic pulse_init();
      cam_dma_init_done = 1'b1;
      repeat (2) next_cycle();
      cam_dma_init_done = 1'b0;
      repeat (2) next_cycle();
   endtask

   task automatic wait_beats(input int n);
      int cycles;
      cycles = 0;
      while (rx_words.size() < n && cycles < BEAT_WAIT) begin
         next_cycle();
         cycles++;
      end
      if (rx_words.size() < n) begin
         $display("Timeout in %s: waited for %0d DMA beats but saw %0d",
                  test_name, n, rx_words.size());
         errors++;
      end
   endtask

   // One window per transfer
   task automatic drain(input int n_words);
      int done;
      done = 0;
      while (done < n_words) begin
         pulse_init();
         done += TRANSFER_LEN;
         wait_beats(done);
      end
   endtask

   task automatic compare_beats();
      int n;
      check_count("beat count", exp_words.size(), rx_words.size());
      n = (exp_words.size() < rx_words.size()) ? exp_words.size() : rx_words.size();
      for (int i = 0; i < n; i++) begin
         check_dma_word($sformatf("beat %0d", i), exp_words[i], rx_words[i]);
         check_bit($sformatf("wlast %0d", i), (i % TRANSFER_LEN) == TRANSFER_LEN - 1,
                   rx_last[i]);
      end
      exp_words.delete();
      rx_words.delete();
      rx_last.delete();
   endtask

   //////////////////////////////////////////////////
   // Tests
   //////////////////////////////////////////////////

   task automatic test_reset_values();
      test_name = "reset_values";
      apply_reset();
      next_cycle();
      check_bit("wvalid", 1'b0, cam_dma_wvalid);
      check_bit("wlast", 1'b0, cam_dma_wlast);
      check_bit("overflow", 1'b0, debug_fifo_overflow);
      check_bit("underflow", 1'b0, debug_fifo_underflow);
      check_count("wcount", 0, debug_fifo_wcount);
      check_count("rcount", 0, debug_fifo_rcount);
      check_count("fps", 0, frames_per_second);
      check_bit("status empty", 1'b1, debug_dma_status[2]);
      check_bit("status window", 1'b0, debug_dma_status[1]);
      check_bit("status wready", 1'b0, debug_dma_status[0]);
   endtask

   task automatic test_single_trigger();
      test_name = "single_trigger";
      apply_reset();
      cam_dma_wready        = 1'b1;
      trigger_capture_frame = 1'b1;
      repeat (8) next_cycle();
      send_frame(FRAME_PAIRS, FRAME_PAIRS);
      send_frame(FRAME_PAIRS, 0);
      send_frame(FRAME_PAIRS, 0);
      drain(TRANSFER_LEN);
      repeat (20) next_cycle();
      compare_beats();
      check_count("wcount", FRAME_PAIRS, debug_fifo_wcount);
      check_count("rcount", TRANSFER_LEN, debug_fifo_rcount);
      // FIFO drained, window closed by the last beat, ready still high
      check_bit("status empty", 1'b1, debug_dma_status[2]);
      check_bit("status window", 1'b0, debug_dma_status[1]);
      check_bit("status wready", 1'b1, debug_dma_status[0]);
   endtask

   task automatic test_continuous_gray();
      test_name = "continuous_gray";
      apply_reset();
      cam_dma_wready           = 1'b1;
      continuous_capture_frame = 1'b1;
      rgb_gray                 = 1'b1;
      gray_on                  = 1'b1;
      repeat (8) next_cycle();
      send_frame(FRAME_PAIRS, FRAME_PAIRS);
      send_frame(FRAME_PAIRS, FRAME_PAIRS);
      drain(2 * TRANSFER_LEN);
      compare_beats();
   endtask

   // Window opens before the frames so beats stall during capture
   task automatic test_back_pressure();
      test_name = "back_pressure";
      apply_reset();
      continuous_capture_frame = 1'b1;
      repeat (8) next_cycle();
      ready_random = 1'b1;
      pulse_init();
      check_bit("status empty", 1'b1, debug_dma_status[2]);
      check_bit("status window", 1'b1, debug_dma_status[1]);
      send_frame(FRAME_PAIRS, FRAME_PAIRS);
      send_frame(FRAME_PAIRS, FRAME_PAIRS);
      wait_beats(TRANSFER_LEN);
      pulse_init();
      wait_beats(2 * TRANSFER_LEN);
      ready_random   = 1'b0;
      cam_dma_wready = 1'b0;
      compare_beats();
      check_bit("overflow", 1'b0, debug_fifo_overflow);
      check_bit("underflow", 1'b0, debug_fifo_underflow);
   endtask

   task automatic test_overflow();
      test_name = "overflow";
      apply_reset();
      continuous_capture_frame = 1'b1;
      repeat (8) next_cycle();
      send_frame(`CAM_FIFO_DEPTH + 16, `CAM_FIFO_DEPTH);
      check_bit("overflow", 1'b1, debug_fifo_overflow);
      cam_dma_wready = 1'b1;
      drain(`CAM_FIFO_DEPTH);
      compare_beats();
      check_count("rcount", `CAM_FIFO_DEPTH, debug_fifo_rcount);
   endtask

   // Five frame starts inside the first 1000-cycle period
   task automatic test_frame_rate();
      test_name = "frame_rate";
      apply_reset();
      repeat (5) begin
         cam_vsync = 1'b1;
         repeat (4) next_cycle();
         cam_vsync = 1'b0;
         repeat (6) next_cycle();
      end
      check_count("fps mid period", 0, frames_per_second);
      repeat (960) next_cycle();
      check_count("fps", 5, frames_per_second);
   endtask

   //////////////////////////////////////////////////
   // Run control
   //////////////////////////////////////////////////

   initial begin
      rst_n                    = 1'b0;
      cam_vsync                = 1'b0;
      pix_valid                = 1'b0;
      pix_data                 = '0;
      trigger_capture_frame    = 1'b0;
      continuous_capture_frame = 1'b0;
      rgb_gray                 = 1'b0;
      cam_dma_init_done        = 1'b0;
      cam_dma_wready           = 1'b0;
      ready_random             = 1'b0;
      gray_on                  = 1'b0;
      errors                   = 0;
      lfsr                     = LFSR_SEED;
      test_reset_values();
      test_single_trigger();
      test_continuous_gray();
      test_back_pressure();
      test_overflow();
      test_frame_rate();
      assert_fails = cam_dma_top_inst.cam_dma_writer_inst.writer_checks.fail_count;
      $display("Errors: %0d check failures, %0d assertion failures", errors, assert_fails);
      if (errors == 0 && assert_fails == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   initial begin
      repeat (2 * TEST_CYCLES) @(posedge mipi_pclk);
      $display("Watchdog expired after %0d cycles in %s", 2 * TEST_CYCLES, test_name);
      $display("Simulation failed");
      $finish;
   end

endmodule

//--- tb.f
+incdir+verilog
verilog/cam_dma_pkg.sv
verilog/cam_capture_ctrl.sv
verilog/pixel_pack.sv
verilog/cam_dma_fifo.sv
verilog/cam_dma_writer.sv
verilog/cam_stats.sv
verilog/cam_dma_top.sv
bench/cam_dma_assertions.sv
bench/cam_dma_tb.sv

//--- verilog/cam_capture_ctrl.sv
/*
 * Capture control
 * Synchronises host controls and selects frames for capture at vsync boundaries
 */
module cam_capture_ctrl (
   input  logic mipi_pclk,
   input  logic rst_n,
   input  logic cam_vsync,
   input  logic trigger_capture_frame,
   input  logic continuous_capture_frame,
   input  logic rgb_gray,
   input  logic fifo_wr,
   output logic capture_frame,
   output logic gray_mode,
   output logic frame_start
);

   logic trig_r1;
   logic trig_r2;
   logic trig_r3;
   logic trig_hold;
   logic cont_r1;
   logic cont_r2;
   logic cont_hold;
   logic gray_r1;
   logic vsync_r;

   // Frame begins on the falling edge of vsync
   assign frame_start = vsync_r && !cam_vsync;

   //////////////////////////////////////////////////
   // Host control synchronisers
   //////////////////////////////////////////////////

   always_ff @(posedge mipi_pclk) begin
      if (!rst_n) begin
         trig_r1   <= 1'b0;
         trig_r2   <= 1'b0;
         trig_r3   <= 1'b0;
         trig_hold <= 1'b0;
         cont_r1   <= 1'b0;
         cont_r2   <= 1'b0;
         cont_hold <= 1'b0;
         gray_r1   <= 1'b0;
         gray_mode <= 1'b0;
         vsync_r   <= 1'b0;
      end else begin
         trig_r1   <= trigger_capture_frame;
         trig_r2   <= trig_r1;
         trig_r3   <= trig_r2;
         // Rising edge arms the trigger, first FIFO write consumes it
         if (trig_r2 && !trig_r3) begin
            trig_hold <= 1'b1;
         end else if (fifo_wr) begin
            trig_hold <= 1'b0;
         end
         cont_r1   <= continuous_capture_frame;
         cont_r2   <= cont_r1;
         // Continuous mode sticks until reset
         if (cont_r2) begin
            cont_hold <= 1'b1;
         end
         gray_r1   <= rgb_gray;
         gray_mode <= gray_r1;
         vsync_r   <= cam_vsync;
      end
   end

   //////////////////////////////////////////////////
   // Capture window
   //////////////////////////////////////////////////

   always_ff @(posedge mipi_pclk) begin
      if (!rst_n) begin
         capture_frame <= 1'b0;
      end else if (frame_start) begin
         if (trig_hold || cont_hold) begin
            capture_frame <= 1'b1;
         end else begin
            capture_frame <= 1'b0;
         end
      end
   end

endmodule

//--- verilog/cam_dma_defines.svh
/*
 * Camera DMA back end constants
 * Pixel and bus widths, FIFO depth and grayscale weights
 */
`ifndef CAM_DMA_DEFINES_SVH
`define CAM_DMA_DEFINES_SVH

// Bits per colour channel
`define CAM_PIX_W 8

// Pixels delivered per clock
`define CAM_PPC 2

// DMA FIFO depth in words, power of two
`define CAM_FIFO_DEPTH 64

// Luma weights, sum is 256 so the result is a shift by 8
`define CAM_GRAY_WR 77
`define CAM_GRAY_WG 150
`define CAM_GRAY_WB 29

// DMA write data width
`define CAM_DMA_W 64

`endif

//--- verilog/cam_dma_fifo.sv
/*
 * DMA FIFO
 * Single clock first-word-fall-through buffer with overflow and underflow pulses
 */
`include "cam_dma_defines.svh"

module cam_dma_fifo #(
   parameter int DEPTH = `CAM_FIFO_DEPTH
) (
   input  logic                   mipi_pclk,
   input  logic                   rst_n,
   input  logic                   wr_en,
   input  cam_dma_pkg::rgb_pair_t wdata,
   input  logic                   rd_en,
   output cam_dma_pkg::rgb_pair_t rdata,
   output logic                   empty,
   output logic                   full,
   output logic                   rd_valid,
   output logic                   overflow,
   output logic                   underflow
);

   localparam int AW = $clog2(DEPTH);

   cam_dma_pkg::rgb_pair_t mem [DEPTH];
   logic [AW:0]            wr_ptr;
   logic [AW:0]            rd_ptr;
   logic                   do_wr;
   logic                   do_rd;

   // Extra pointer bit tells full from empty
   assign empty = (wr_ptr == rd_ptr);
   assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

   assign do_wr = wr_en && !full;
   assign do_rd = rd_en && !empty;

   // Head word is visible without a read request
   assign rdata    = mem[rd_ptr[AW-1:0]];
   assign rd_valid = do_rd;

   //////////////////////////////////////////////////
   // Storage
   //////////////////////////////////////////////////

   always_ff @(posedge mipi_pclk) begin
      if (do_wr) begin
         mem[wr_ptr[AW-1:0]] <= wdata;
      end
   end

   //////////////////////////////////////////////////
   // Pointers and error pulses
   //////////////////////////////////////////////////

   always_ff @(posedge mipi_pclk) begin
      if (!rst_n) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         overflow  <= 1'b0;
         underflow <= 1'b0;
      end else begin
         if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // Write while full is dropped
         overflow  <= wr_en && full;
         underflow <= rd_en && empty;
      end
   end

endmodule

//--- verilog/cam_dma_pkg.sv
/*
 * Camera DMA types
 * Pixel, FIFO word and DMA beat layouts shared by the back end
 */
`include "cam_dma_defines.svh"

package cam_dma_pkg;

   //////////////////////////////////////////////////
   // Pixel types
   //////////////////////////////////////////////////

   // Blue sits in the upper byte, red in the lower
   typedef struct packed {
      logic [`CAM_PIX_W-1:0] b;
      logic [`CAM_PIX_W-1:0] g;
      logic [`CAM_PIX_W-1:0] r;
   } rgb_pix_t;

   // Element 0 is the earlier pixel, also the FIFO word
   typedef rgb_pix_t [`CAM_PPC-1:0] rgb_pair_t;

   //////////////////////////////////////////////////
   // DMA beat
   //////////////////////////////////////////////////

   // Each half is a zero pad byte over one pixel
   typedef struct packed {
      logic [`CAM_DMA_W/2-3*`CAM_PIX_W-1:0] pad1;
      rgb_pix_t                              pix1;
      logic [`CAM_DMA_W/2-3*`CAM_PIX_W-1:0] pad0;
      rgb_pix_t                              pix0;
   } dma_word_t;

endpackage

//--- verilog/cam_dma_top.sv
/*
 * Camera frame capture and DMA write-out
 * Capture control, packing, FIFO, DMA writer and statistics
 */
module cam_dma_top #(
   parameter int TRANSFER_LEN = 1920,
   parameter int CLK_RATE     = 100000000
) (
   input  logic                   mipi_pclk,
   input  logic                   rst_n,
   // Pixel stream
   input  logic                   cam_vsync,
   input  logic                   pix_valid,
   input  cam_dma_pkg::rgb_pair_t pix_data,
   // Host controls
   input  logic                   trigger_capture_frame,
   input  logic                   continuous_capture_frame,
   input  logic                   rgb_gray,
   input  logic                   cam_dma_init_done,
   // DMA write channel
   input  logic                   cam_dma_wready,
   output logic                   cam_dma_wvalid,
   output logic                   cam_dma_wlast,
   output cam_dma_pkg::dma_word_t cam_dma_wdata,
   // Status
   output logic                   debug_fifo_overflow,
   output logic                   debug_fifo_underflow,
   output logic [31:0]            debug_fifo_wcount,
   output logic [31:0]            debug_fifo_rcount,
   output logic [2:0]             debug_dma_status,
   output logic [31:0]            frames_per_second
);

   logic                   capture_frame;
   logic                   gray_mode;
   logic                   frame_start;
   logic                   fifo_wr;
   cam_dma_pkg::rgb_pair_t fifo_wdata;
   logic                   fifo_rd;
   cam_dma_pkg::rgb_pair_t fifo_rdata;
   logic                   fifo_empty;
   logic                   fifo_overflow;
   logic                   fifo_underflow;
   logic                   dma_write;

   cam_capture_ctrl cam_capture_ctrl_inst (
      .mipi_pclk                (mipi_pclk),
      .rst_n                    (rst_n),
      .cam_vsync                (cam_vsync),
      .trigger_capture_frame    (trigger_capture_frame),
      .continuous_capture_frame (continuous_capture_frame),
      .rgb_gray                 (rgb_gray),
      .fifo_wr                  (fifo_wr),
      .capture_frame            (capture_frame),
      .gray_mode                (gray_mode),
      .frame_start              (frame_start)
   );

   pixel_pack pixel_pack_inst (
      .mipi_pclk     (mipi_pclk),
      .rst_n         (rst_n),
      .pix_valid     (pix_valid),
      .pix_data      (pix_data),
      .capture_frame (capture_frame),
      .gray_mode     (gray_mode),
      .wr_en         (fifo_wr),
      .wdata         (fifo_wdata)
   );

   cam_dma_fifo cam_dma_fifo_inst (
      .mipi_pclk (mipi_pclk),
      .rst_n     (rst_n),
      .wr_en     (fifo_wr),
      .wdata     (fifo_wdata),
      .rd_en     (fifo_rd),
      .rdata     (fifo_rdata),
      .empty     (fifo_empty),
      .full      (),
      .rd_valid  (),
      .overflow  (fifo_overflow),
      .underflow (fifo_underflow)
   );

   cam_dma_writer #(
      .TRANSFER_LEN (TRANSFER_LEN)
   ) cam_dma_writer_inst (
      .mipi_pclk         (mipi_pclk),
      .rst_n             (rst_n),
      .cam_dma_init_done (cam_dma_init_done),
      .cam_dma_wready    (cam_dma_wready),
      .fifo_empty        (fifo_empty),
      .fifo_rdata        (fifo_rdata),
      .fifo_rd           (fifo_rd),
      .dma_write         (dma_write),
      .cam_dma_wvalid    (cam_dma_wvalid),
      .cam_dma_wlast     (cam_dma_wlast),
      .cam_dma_wdata     (cam_dma_wdata)
   );

   // wvalid already includes wready, so it marks a beat
   cam_stats #(
      .CLK_RATE (CLK_RATE)
   ) cam_stats_inst (
      .mipi_pclk            (mipi_pclk),
      .rst_n                (rst_n),
      .fifo_overflow        (fifo_overflow),
      .fifo_underflow       (fifo_underflow),
      .fifo_wr              (fifo_wr),
      .dma_beat             (cam_dma_wvalid),
      .frame_start          (frame_start),
      .fifo_empty           (fifo_empty),
      .dma_write            (dma_write),
      .cam_dma_wready       (cam_dma_wready),
      .debug_fifo_overflow  (debug_fifo_overflow),
      .debug_fifo_underflow (debug_fifo_underflow),
      .debug_fifo_wcount    (debug_fifo_wcount),
      .debug_fifo_rcount    (debug_fifo_rcount),
      .debug_dma_status     (debug_dma_status),
      .frames_per_second    (frames_per_second)
   );

endmodule

//--- verilog/cam_dma_writer.sv
/*
 * DMA writer
 * Opens a transfer window per init_done edge, counts beats and formats data
 */
module cam_dma_writer #(
   parameter int TRANSFER_LEN = 1920
) (
   input  logic                   mipi_pclk,
   input  logic                   rst_n,
   input  logic                   cam_dma_init_done,
   input  logic                   cam_dma_wready,
   input  logic                   fifo_empty,
   input  cam_dma_pkg::rgb_pair_t fifo_rdata,
   output logic                   fifo_rd,
   output logic                   dma_write,
   output logic                   cam_dma_wvalid,
   output logic                   cam_dma_wlast,
   output cam_dma_pkg::dma_word_t cam_dma_wdata
);

   localparam int CW = (TRANSFER_LEN > 1) ? $clog2(TRANSFER_LEN) : 1;

   logic          init_r1;
   logic          init_r2;
   logic          init_r3;
   logic [CW-1:0] beat_cnt;
   logic          at_last;

   assign at_last = (beat_cnt == CW'(TRANSFER_LEN - 1));

   // Pop and beat happen together
   assign fifo_rd        = dma_write && cam_dma_wready && !fifo_empty;
   assign cam_dma_wvalid = fifo_rd;
   assign cam_dma_wlast  = cam_dma_wvalid && at_last;

   //////////////////////////////////////////////////
   // Beat formatting
   //////////////////////////////////////////////////

   always_comb begin
      cam_dma_wdata      = '0;
      cam_dma_wdata.pix1 = fifo_rdata[1];
      cam_dma_wdata.pix0 = fifo_rdata[0];
   end

   //////////////////////////////////////////////////
   // Window and beat counter
   //////////////////////////////////////////////////

   always_ff @(posedge mipi_pclk) begin
      if (!rst_n) begin
         init_r1   <= 1'b0;
         init_r2   <= 1'b0;
         init_r3   <= 1'b0;
         dma_write <= 1'b0;
         beat_cnt  <= '0;
      end else begin
         init_r1 <= cam_dma_init_done;
         init_r2 <= init_r1;
         init_r3 <= init_r2;
         if (init_r2 && !init_r3) begin
            dma_write <= 1'b1;
         end else if (cam_dma_wlast) begin
            dma_write <= 1'b0;
         end
         // Wraps on the last beat of each transfer
         if (cam_dma_wlast) begin
            beat_cnt <= '0;
         end else if (cam_dma_wvalid) begin
            beat_cnt <= beat_cnt + 1'b1;
         end
      end
   end

endmodule

//--- verilog/cam_stats.sv
/*
 * Back end statistics
 * Sticky FIFO errors, write and beat counts, DMA status and frame rate
 */
module cam_stats #(
   parameter int CLK_RATE = 100000000
) (
   input  logic        mipi_pclk,
   input  logic        rst_n,
   input  logic        fifo_overflow,
   input  logic        fifo_underflow,
   input  logic        fifo_wr,
   input  logic        dma_beat,
   input  logic        frame_start,
   input  logic        fifo_empty,
   input  logic        dma_write,
   input  logic        cam_dma_wready,
   output logic        debug_fifo_overflow,
   output logic        debug_fifo_underflow,
   output logic [31:0] debug_fifo_wcount,
   output logic [31:0] debug_fifo_rcount,
   output logic [2:0]  debug_dma_status,
   output logic [31:0] frames_per_second
);

   logic [31:0] timer_cnt;
   logic [31:0] frame_cnt;
   logic        period_end;

   assign period_end       = (timer_cnt == 32'(CLK_RATE));
   assign debug_dma_status = {fifo_empty, dma_write, cam_dma_wready};

   //////////////////////////////////////////////////
   // Error flags and counters
   //////////////////////////////////////////////////

   always_ff @(posedge mipi_pclk) begin
      if (!rst_n) begin
         debug_fifo_overflow  <= 1'b0;
         debug_fifo_underflow <= 1'b0;
         debug_fifo_wcount    <= '0;
         debug_fifo_rcount    <= '0;
      end else begin
         if (fifo_overflow) begin
            debug_fifo_overflow <= 1'b1;
         end
         if (fifo_underflow) begin
            debug_fifo_underflow <= 1'b1;
         end
         if (fifo_wr) begin
            debug_fifo_wcount <= debug_fifo_wcount + 1'b1;
         end
         if (dma_beat) begin
            debug_fifo_rcount <= debug_fifo_rcount + 1'b1;
         end
      end
   end

   //////////////////////////////////////////////////
   // Frame rate
   //////////////////////////////////////////////////

   always_ff @(posedge mipi_pclk) begin
      if (!rst_n) begin
         timer_cnt         <= '0;
         frame_cnt         <= '0;
         frames_per_second <= '0;
      end else if (period_end) begin
         timer_cnt         <= '0;
         // A frame start on the boundary still belongs to this period
         frames_per_second <= frame_cnt + frame_start;
         frame_cnt         <= '0;
      end else begin
         timer_cnt <= timer_cnt + 1'b1;
         if (frame_start) begin
            frame_cnt <= frame_cnt + 1'b1;
         end
      end
   end

endmodule

//--- verilog/pixel_pack.sv
/*
 * Pixel packer
 * Optional grayscale conversion, registers two pixels into one FIFO word
 */
`include "cam_dma_defines.svh"

module pixel_pack (
   input  logic                  mipi_pclk,
   input  logic                  rst_n,
   input  logic                  pix_valid,
   input  cam_dma_pkg::rgb_pair_t pix_data,
   input  logic                  capture_frame,
   input  logic                  gray_mode,
   output logic                  wr_en,
   output cam_dma_pkg::rgb_pair_t wdata
);

   cam_dma_pkg::rgb_pair_t gray_pair;

   // Weighted sum, top byte is the luma value
   function automatic logic [`CAM_PIX_W-1:0] gray_of(input cam_dma_pkg::rgb_pix_t p);
      logic [2*`CAM_PIX_W-1:0] acc;
      acc = (2*`CAM_PIX_W)'(`CAM_GRAY_WR * p.r + `CAM_GRAY_WG * p.g + `CAM_GRAY_WB * p.b);
      return acc[2*`CAM_PIX_W-1:`CAM_PIX_W];
   endfunction

   //////////////////////////////////////////////////
   // Grayscale, replicated over all three channels
   //////////////////////////////////////////////////

   always_comb begin
      for (int i = 0; i < `CAM_PPC; i++) begin
         gray_pair[i].r = gray_of(pix_data[i]);
         gray_pair[i].g = gray_of(pix_data[i]);
         gray_pair[i].b = gray_of(pix_data[i]);
      end
   end

   //////////////////////////////////////////////////
   // Output register
   //////////////////////////////////////////////////

   always_ff @(posedge mipi_pclk) begin
      if (!rst_n) begin
         wr_en <= 1'b0;
      end else begin
         wr_en <= pix_valid && capture_frame;
      end
   end

   // Payload only, qualified by wr_en
   always_ff @(posedge mipi_pclk) begin
      if (pix_valid) begin
         wdata <= gray_mode ? gray_pair : pix_data;
      end
   end

endmodule
